// ==== defusedBanner.f ====
bannerPkg.sv
pixelBus.sv
pixelOffset.sv
segmentMatch.sv
pixelCombine.sv
defusedBanner.sv
defusedBanner_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the banner testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module defusedBanner_tb \
  -f defusedBanner.f -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "^No errors$" sim.log \
  && echo "simulation passed" \
  || { cat sim.log; echo "simulation failed"; exit 1; }

// ==== defusedBanner_tb.sv ====
`timescale 1ns/1ps

module defusedBanner_tb;

  localparam int NUM_SEGS     = bannerPkg::SEG_COUNT;
  localparam int BLINK_FRAMES = 16;
  localparam int DRAIN_LIMIT  = 20;

  logic                      clk;
  logic                      nrst;
  logic [bannerPkg::X_W-1:0] x;
  logic [bannerPkg::Y_W-1:0] y;
  logic                      pixelValid;
  logic [bannerPkg::X_W-1:0] originX;
  logic [bannerPkg::Y_W-1:0] originY;
  bannerPkg::bannerMode      mode;
  logic                      frameStart;
  logic                      bannerPixel;
  logic                      pixelOut;

  // shape result of every driven valid pixel, oldest first
  bit    shapeQueue[$];
  int    errors;
  int    checked;
  string testName;

  // model state for the valid pipeline and the blink phase
  logic [2:0] validPipe;
  int         frameCount;
  bit         phaseShown;
  bit         lastVisible;

  defusedBanner #(
    .NUM_SEGS     (NUM_SEGS),
    .BLINK_FRAMES (BLINK_FRAMES)
  ) defusedBanner_inst (
    .clk         (clk),
    .nrst        (nrst),
    .x           (x),
    .y           (y),
    .pixelValid  (pixelValid),
    .originX     (originX),
    .originY     (originY),
    .mode        (mode),
    .frameStart  (frameStart),
    .bannerPixel (bannerPixel),
    .pixelOut    (pixelOut)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic checkValue(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  // row counts across the bar, col along it
  function automatic bit onTaperedBar(input int row, input int col);
    int edgeDist;
    int margin;
    if (row < 0 || row > 4 || col < 0 || col > 19) begin
      return 1'b0;
    end
    edgeDist = (row < 4 - row) ? row : 4 - row;
    margin = 2 - edgeDist;
    return (col >= margin) && (col <= 19 - margin);
  endfunction

  function automatic bit expectShape(input int sx, input int sy, input int ox, input int oy);
    int                 lx;
    int                 ly;
    bit                 hitAny;
    bannerPkg::segEntry seg;
    lx = sx - ox;
    ly = sy - oy;
    hitAny = 1'b0;
    if (lx < 0 || lx >= int'(bannerPkg::BANNER_W) ||
        ly < 0 || ly >= int'(bannerPkg::BANNER_H)) begin
      return 1'b0;
    end
    for (int i = 0; i < NUM_SEGS; i++) begin
      seg = bannerPkg::segTable[i];
      if (seg.orient == bannerPkg::HORIZONTAL) begin
        if (onTaperedBar(ly - int'(seg.y), lx - int'(seg.x))) begin
          hitAny = 1'b1;
        end
      end else if (onTaperedBar(lx - int'(seg.x), ly - int'(seg.y))) begin
        hitAny = 1'b1;
      end
    end
    return hitAny;
  endfunction

  task automatic drivePixel(input bit valid, input int sx, input int sy, input bit pulse);
    logic [bannerPkg::X_W-1:0] xv;
    logic [bannerPkg::Y_W-1:0] yv;
    xv = sx[bannerPkg::X_W-1:0];
    yv = sy[bannerPkg::Y_W-1:0];
    @(posedge clk);
    x          <= xv;
    y          <= yv;
    pixelValid <= valid;
    frameStart <= pulse;
    if (valid) begin
      shapeQueue.push_back(expectShape(int'(xv), int'(yv), int'(originX), int'(originY)));
    end
  endtask

  task automatic setControls(input bannerPkg::bannerMode m, input int ox, input int oy);
    @(posedge clk);
    mode       <= m;
    originX    <= ox[bannerPkg::X_W-1:0];
    originY    <= oy[bannerPkg::Y_W-1:0];
    pixelValid <= 1'b0;
    frameStart <= 1'b0;
  endtask

  // coordinates spread a little past the window edges
  task automatic driveNearBanner(input int count, input int validPct, input int pulsePct);
    int sx;
    int sy;
    for (int i = 0; i < count; i++) begin
      sx = int'(originX) - 8 + int'($urandom_range(0, 230));
      sy = int'(originY) - 6 + int'($urandom_range(0, 62));
      drivePixel($urandom_range(0, 99) < validPct, sx, sy, $urandom_range(0, 99) < pulsePct);
    end
  endtask

  task automatic waitForDrain();
    int waited;
    waited = 0;
    @(posedge clk);
    pixelValid <= 1'b0;
    frameStart <= 1'b0;
    while (shapeQueue.size() > 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (shapeQueue.size() > 0) begin
      $display("timeout in %s: output stopped arriving, %0d pixels never came out",
               testName, shapeQueue.size());
      errors++;
      shapeQueue.delete();
    end
  endtask

  // outputs read here were registered on the previous edge
  always @(posedge clk) begin : modelCheck
    bit expShape;
    if (!nrst) begin
      validPipe   = '0;
      frameCount  = 0;
      phaseShown  = 1'b1;
      lastVisible = 1'b0;
    end else begin
      checkValue({testName, " pixelOut"}, int'(validPipe[2]), int'(pixelOut));
      if (pixelOut) begin
        if (shapeQueue.size() == 0) begin
          $display("%s: a pixel came out with no driven pixel left to match it", testName);
          errors++;
        end else begin
          expShape = shapeQueue.pop_front();
          checkValue({testName, " bannerPixel"}, int'(expShape && lastVisible),
                     int'(bannerPixel));
          checked++;
        end
      end else begin
        checkValue({testName, " idle bannerPixel"}, 0, int'(bannerPixel));
      end
      // visibility used by the combine stage on this edge
      case (mode)
        bannerPkg::SOLID: lastVisible = 1'b1;
        bannerPkg::BLINK: lastVisible = phaseShown;
        default:          lastVisible = 1'b0;
      endcase
      if (mode != bannerPkg::BLINK) begin
        frameCount = 0;
        phaseShown = 1'b1;
      end else if (frameStart) begin
        if (frameCount == BLINK_FRAMES - 1) begin
          frameCount = 0;
          phaseShown = !phaseShown;
        end else begin
          frameCount++;
        end
      end
      validPipe = {validPipe[1:0], pixelValid};
    end
  end

  initial begin
    void'($urandom(19068));
    errors     = 0;
    checked    = 0;
    testName   = "reset";
    nrst       = 1'b0;
    x          = '0;
    y          = '0;
    pixelValid = 1'b0;
    originX    = 9'd55;
    originY    = 8'd96;
    mode       = bannerPkg::SOLID;
    frameStart = 1'b0;
    repeat (8) @(posedge clk);
    nrst <= 1'b1;

    testName = "after reset";
    repeat (4) drivePixel(1'b0, 0, 0, 1'b0);
    drivePixel(1'b1, 61, 96, 1'b0);
    waitForDrain();

    // tapered corner of the top-left bar, then random pixels
    testName = "solid default origin";
    setControls(bannerPkg::SOLID, 55, 96);
    drivePixel(1'b1, 60, 96, 1'b0);
    drivePixel(1'b1, 61, 96, 1'b0);
    driveNearBanner(400, 100, 0);
    waitForDrain();

    testName = "random origin";
    for (int b = 0; b < 6; b++) begin
      setControls(bannerPkg::SOLID, int'($urandom_range(0, 300)), int'($urandom_range(0, 200)));
      driveNearBanner(120, 100, 0);
      repeat (30) drivePixel(1'b1, int'($urandom_range(0, 511)),
                             int'($urandom_range(0, 255)), 1'b0);
    end
    waitForDrain();

    testName = "hidden";
    setControls(bannerPkg::HIDDEN, 55, 96);
    driveNearBanner(200, 100, 0);
    waitForDrain();

    testName = "blink";
    setControls(bannerPkg::BLINK, 55, 96);
    driveNearBanner(1500, 100, 25);
    setControls(bannerPkg::SOLID, 55, 96);
    driveNearBanner(60, 100, 25);
    setControls(bannerPkg::BLINK, 55, 96);
    driveNearBanner(300, 100, 40);
    waitForDrain();

    testName = "valid gaps";
    setControls(bannerPkg::SOLID, 55, 96);
    driveNearBanner(400, 50, 0);
    waitForDrain();

    $display("checks done: %0d pixels compared, error count %0d", checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== defusedBanner.sv ====
`timescale 1ns/1ps

module defusedBanner #(
  parameter int NUM_SEGS     = bannerPkg::SEG_COUNT,
  parameter int BLINK_FRAMES = 16
) (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic [bannerPkg::X_W-1:0] x,
  input  logic [bannerPkg::Y_W-1:0] y,
  input  logic                      pixelValid,
  input  logic [bannerPkg::X_W-1:0] originX,
  input  logic [bannerPkg::Y_W-1:0] originY,
  input  bannerPkg::bannerMode      mode,
  input  logic                      frameStart,
  output logic                      bannerPixel,
  output logic                      pixelOut
);

  logic [NUM_SEGS-1:0] segHits;
  logic [NUM_SEGS-1:0] hitValid;

  pixelBus localBus ();

  pixelOffset pixelOffset_inst (
    .clk        (clk),
    .nrst       (nrst),
    .x          (x),
    .y          (y),
    .pixelValid (pixelValid),
    .originX    (originX),
    .originY    (originY),
    .bus        (localBus.driver)
  );

  // one matcher per bar in the table
  for (genvar g = 0; g < NUM_SEGS; g++) begin : gMatch
    segmentMatch #(
      .SEG_INDEX (g)
    ) segmentMatch_inst (
      .clk      (clk),
      .nrst     (nrst),
      .bus      (localBus.receiver),
      .hit      (segHits[g]),
      .hitValid (hitValid[g])
    );
  end

  pixelCombine #(
    .NUM_SEGS     (NUM_SEGS),
    .BLINK_FRAMES (BLINK_FRAMES)
  ) pixelCombine_inst (
    .clk         (clk),
    .nrst        (nrst),
    .segHits     (segHits),
    .hitValid    (hitValid[0]),
    .mode        (mode),
    .frameStart  (frameStart),
    .bannerPixel (bannerPixel),
    .pixelOut    (pixelOut)
  );

endmodule

// ==== pixelCombine.sv ====
`timescale 1ns/1ps

module pixelCombine #(
  parameter int NUM_SEGS     = 32,
  parameter int BLINK_FRAMES = 16
) (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic [NUM_SEGS-1:0]  segHits,
  input  logic                 hitValid,
  input  bannerPkg::bannerMode mode,
  input  logic                 frameStart,
  output logic                 bannerPixel,
  output logic                 pixelOut
);

  localparam int CNT_W = (BLINK_FRAMES > 1) ? $clog2(BLINK_FRAMES) : 1;
  localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(BLINK_FRAMES - 1);

  logic [CNT_W-1:0] frameCount;
  logic             phaseShown;
  logic             anyHit;
  logic             visible;

  always_comb begin
    anyHit = |segHits;
    case (mode)
      bannerPkg::SOLID: visible = 1'b1;
      bannerPkg::BLINK: visible = phaseShown;
      default:          visible = 1'b0;
    endcase
  end

  // blink phase flips once every BLINK_FRAMES frame pulses
  always_ff @(posedge clk) begin
    if (!nrst) begin
      frameCount <= '0;
      phaseShown <= 1'b1;
    end else if (mode != bannerPkg::BLINK) begin
      frameCount <= '0;
      phaseShown <= 1'b1;
    end else if (frameStart) begin
      if (frameCount == LAST_FRAME) begin
        frameCount <= '0;
        phaseShown <= !phaseShown;
      end else begin
        frameCount <= frameCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      bannerPixel <= 1'b0;
      pixelOut    <= 1'b0;
    end else begin
      bannerPixel <= hitValid && visible && anyHit;
      pixelOut    <= hitValid;
    end
  end

  hiddenIsDark: assert property (
    @(posedge clk) disable iff (!nrst)
    (mode == bannerPkg::HIDDEN) |=> !bannerPixel
  );

endmodule

// ==== segmentMatch.sv ====
`timescale 1ns/1ps

module segmentMatch #(
  parameter int SEG_INDEX = 0
) (
  input  logic       clk,
  input  logic       nrst,
  pixelBus.receiver  bus,
  output logic       hit,
  output logic       hitValid
);

  localparam bannerPkg::segEntry SEG = bannerPkg::segTable[SEG_INDEX];

  // bar footprint, long side by short side
  localparam logic [bannerPkg::X_W-1:0] BAR_LEN   = 20;
  localparam logic [bannerPkg::X_W-1:0] BAR_THICK = 5;

  logic [bannerPkg::X_W-1:0] relX;
  logic [bannerPkg::Y_W-1:0] relY;
  logic [bannerPkg::X_W-1:0] along;
  logic [bannerPkg::X_W-1:0] across;
  logic                      pastCorner;
  logic                      onBar;

  // tapered profile: outer rows lose two pixels at each end, next rows one
  function automatic logic barRule(input logic [2:0] row, input logic [4:0] col);
    case (row)
      3'd0, 3'd4: barRule = (col >= 5'd2) && (col <= 5'd17);
      3'd1, 3'd3: barRule = (col >= 5'd1) && (col <= 5'd18);
      3'd2:       barRule = (col <= 5'd19);
      default:    barRule = 1'b0;
    endcase
  endfunction

  always_comb begin
    relX = bus.localX - SEG.x;
    relY = bus.localY - SEG.y;
    pastCorner = (bus.localX >= SEG.x) && (bus.localY >= SEG.y);
    // vertical bars use the same rule with the axes swapped
    if (SEG.orient == bannerPkg::HORIZONTAL) begin
      along  = relX;
      across = {{(bannerPkg::X_W - bannerPkg::Y_W){1'b0}}, relY};
    end else begin
      along  = {{(bannerPkg::X_W - bannerPkg::Y_W){1'b0}}, relY};
      across = relX;
    end
    onBar = pastCorner && (along < BAR_LEN) && (across < BAR_THICK) &&
            barRule(across[2:0], along[4:0]);
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      hit      <= 1'b0;
      hitValid <= 1'b0;
    end else begin
      hit      <= onBar && bus.inWindow && bus.pixelValid;
      hitValid <= bus.pixelValid;
    end
  end

  hitNeedsValid: assert property (
    @(posedge clk) disable iff (!nrst)
    !hitValid |-> !hit
  );

endmodule

// ==== pixelOffset.sv ====
`timescale 1ns/1ps

module pixelOffset (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic [bannerPkg::X_W-1:0] x,
  input  logic [bannerPkg::Y_W-1:0] y,
  input  logic                      pixelValid,
  input  logic [bannerPkg::X_W-1:0] originX,
  input  logic [bannerPkg::Y_W-1:0] originY,
  pixelBus.driver                   bus
);

  logic [bannerPkg::X_W-1:0] dx;
  logic [bannerPkg::Y_W-1:0] dy;
  logic                      inWin;

  // dx is only exact when x is at or past the origin, so that check comes first
  always_comb begin
    dx = x - originX;
    dy = y - originY;
    inWin = (x >= originX) && (dx < bannerPkg::BANNER_W) &&
            (y >= originY) && (dy < bannerPkg::BANNER_H);
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      bus.localX     <= '0;
      bus.localY     <= '0;
      bus.inWindow   <= 1'b0;
      bus.pixelValid <= 1'b0;
    end else begin
      bus.localX     <= dx;
      bus.localY     <= dy;
      bus.inWindow   <= inWin;
      bus.pixelValid <= pixelValid;
    end
  end

  // a windowed pixel never lands outside the banner area
  localCoordInRange: assert property (
    @(posedge clk) disable iff (!nrst)
    (bus.pixelValid && bus.inWindow) |->
      (bus.localX < bannerPkg::BANNER_W) && (bus.localY < bannerPkg::BANNER_H)
  );

endmodule

// ==== pixelBus.sv ====
`timescale 1ns/1ps

interface pixelBus;

  // coordinate relative to the banner origin
  logic [bannerPkg::X_W-1:0] localX;
  logic [bannerPkg::Y_W-1:0] localY;
  logic                      inWindow;
  logic                      pixelValid;

  modport driver (
    output localX,
    output localY,
    output inWindow,
    output pixelValid
  );

  modport receiver (
    input localX,
    input localY,
    input inWindow,
    input pixelValid
  );

endinterface

// ==== bannerPkg.sv ====
package bannerPkg;

  localparam int X_W = 9;
  localparam int Y_W = 8;

  // local window that holds every bar
  localparam logic [X_W-1:0] BANNER_W = 9'd215;
  localparam logic [Y_W-1:0] BANNER_H = 8'd50;

  localparam int SEG_COUNT = 32;

  typedef enum logic {
    HORIZONTAL,
    VERTICAL
  } segOrient;

  typedef enum logic [1:0] {
    HIDDEN,
    SOLID,
    BLINK
  } bannerMode;

  // top-left corner of one bar, relative to the banner origin
  typedef struct packed {
    segOrient        orient;
    logic [X_W-1:0]  x;
    logic [Y_W-1:0]  y;
  } segEntry;

  localparam segEntry segTable [SEG_COUNT] = '{
    // horizontal bars
    '{HORIZONTAL, 9'd4,   8'd42},
    '{HORIZONTAL, 9'd4,   8'd0},
    '{HORIZONTAL, 9'd33,  8'd0},
    '{HORIZONTAL, 9'd33,  8'd21},
    '{HORIZONTAL, 9'd33,  8'd42},
    '{HORIZONTAL, 9'd66,  8'd0},
    '{HORIZONTAL, 9'd66,  8'd21},
    '{HORIZONTAL, 9'd66,  8'd42},
    '{HORIZONTAL, 9'd101, 8'd0},
    '{HORIZONTAL, 9'd128, 8'd21},
    '{HORIZONTAL, 9'd128, 8'd42},
    '{HORIZONTAL, 9'd157, 8'd0},
    '{HORIZONTAL, 9'd157, 8'd21},
    '{HORIZONTAL, 9'd157, 8'd42},
    '{HORIZONTAL, 9'd190, 8'd0},
    '{HORIZONTAL, 9'd190, 8'd42},
    // vertical bars
    '{VERTICAL,   9'd0,   8'd3},
    '{VERTICAL,   9'd0,   8'd24},
    '{VERTICAL,   9'd52,  8'd3},
    '{VERTICAL,   9'd52,  8'd24},
    '{VERTICAL,   9'd62,  8'd3},
    '{VERTICAL,   9'd85,  8'd24},
    '{VERTICAL,   9'd95,  8'd3},
    '{VERTICAL,   9'd95,  8'd24},
    '{VERTICAL,   9'd118, 8'd3},
    '{VERTICAL,   9'd118, 8'd24},
    '{VERTICAL,   9'd147, 8'd3},
    '{VERTICAL,   9'd147, 8'd24},
    '{VERTICAL,   9'd176, 8'd3},
    '{VERTICAL,   9'd176, 8'd24},
    '{VERTICAL,   9'd186, 8'd3},
    '{VERTICAL,   9'd186, 8'd24}
  };

endpackage
